// ==== hdl/rv_core_cfg.svh ====
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// first fetch address after reset.
`define RV_RESET_PC 32'h0000_0000

// l1 instruction cache geometry.
`define RV_L1I_LINES 4
`define RV_L1I_WORDS 2
`define RV_L1I_IDX_W 2 // log2 of lines.
`define RV_L1I_OFF_W 1 // log2 of words per line.

// major opcodes, inst[6:0].
`define RV_OP_LUI      7'b0110111
`define RV_OP_IMM      7'b0010011
`define RV_OP_REG      7'b0110011
`define RV_OP_BRANCH   7'b1100011
`define RV_OP_JAL      7'b1101111
`define RV_OP_MISC_MEM 7'b0001111

// fence.i with rd, rs1 and imm all zero.
`define RV_INST_FENCE_I 32'h0000_100f

`endif

// ==== hdl/rv_core_pkg.sv ====
`default_nettype none

`include "rv_core_cfg.svh"

package rv_core_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [6:0]  opcode_t;

  // pc fields used by the instruction cache.
  typedef logic [`RV_L1I_IDX_W-1:0] l1i_idx_t;
  typedef logic [`RV_L1I_OFF_W-1:0] l1i_off_t;
  typedef logic [31-`RV_L1I_IDX_W-`RV_L1I_OFF_W-2:0] l1i_tag_t;

  typedef enum logic [1:0]
  {
    ALU_ADD,
    ALU_SUB,
    ALU_PASS_B // lui result.
  } alu_op_e;

  // fetch sits in WAIT_PC while an instruction is in flight.
  typedef enum logic [1:0]
  {
    LOOKUP,
    FILL_LO,
    FILL_HI,
    WAIT_PC
  } fetch_state_e;

endpackage

`default_nettype wire

// ==== hdl/rv_fetch.sv ====
`default_nettype none

`include "rv_core_cfg.svh"

module rv_fetch (
  input  logic               clk,
  input  logic               rst,
  input  logic               pc_valid_i,
  input  rv_core_pkg::addr_t next_pc_i,
  output logic               psel_o,
  output logic               penable_o,
  output rv_core_pkg::addr_t paddr_o,
  input  rv_core_pkg::word_t prdata_i,
  input  logic               pready_i,
  output logic               inst_valid_o,
  output rv_core_pkg::word_t inst_o,
  output rv_core_pkg::addr_t pc_o
);

  localparam int unsigned IDX_LSB = 2 + `RV_L1I_OFF_W;
  localparam int unsigned TAG_LSB = IDX_LSB + `RV_L1I_IDX_W;

  rv_core_pkg::fetch_state_e state_q;
  rv_core_pkg::addr_t        pc_q;

  rv_core_pkg::word_t    l1i_data [`RV_L1I_LINES][`RV_L1I_WORDS];
  rv_core_pkg::l1i_tag_t l1i_tag [`RV_L1I_LINES];
  logic [`RV_L1I_LINES-1:0] l1i_valid;

  rv_core_pkg::l1i_off_t pc_off;
  rv_core_pkg::l1i_idx_t pc_idx;
  rv_core_pkg::l1i_tag_t pc_tag;
  logic                  hit;
  logic                  xfer_done;

  assign pc_off = pc_q[IDX_LSB-1:2];
  assign pc_idx = pc_q[TAG_LSB-1:IDX_LSB];
  assign pc_tag = pc_q[31:TAG_LSB];

  // lookup is combinational from the registered pc.
  assign hit = (state_q == rv_core_pkg::LOOKUP) && l1i_valid[pc_idx]
               && (l1i_tag[pc_idx] == pc_tag);

  assign xfer_done = psel_o && penable_o && pready_i; // apb access completes.

  assign inst_valid_o = hit;
  assign inst_o       = l1i_data[pc_idx][pc_off];
  assign pc_o         = pc_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q   <= rv_core_pkg::LOOKUP;
      pc_q      <= `RV_RESET_PC;
      psel_o    <= 1'b0;
      penable_o <= 1'b0;
      l1i_valid <= '0;
    end
    else
    begin
      case (state_q)
        rv_core_pkg::LOOKUP:
          if (hit)
          begin
            state_q <= rv_core_pkg::WAIT_PC;
            if (inst_o == `RV_INST_FENCE_I)
              l1i_valid <= '0; // flush the whole cache.
          end
          else
          begin
            state_q <= rv_core_pkg::FILL_LO;
            psel_o  <= 1'b1; // setup phase of the low word.
          end
        rv_core_pkg::FILL_LO:
          if (!penable_o)
            penable_o <= 1'b1;
          else if (pready_i)
          begin
            // psel stays high, next cycle is the high word's setup.
            penable_o <= 1'b0;
            state_q   <= rv_core_pkg::FILL_HI;
          end
        rv_core_pkg::FILL_HI:
          if (!penable_o)
            penable_o <= 1'b1;
          else if (pready_i)
          begin
            psel_o            <= 1'b0;
            penable_o         <= 1'b0;
            l1i_valid[pc_idx] <= 1'b1;
            state_q           <= rv_core_pkg::LOOKUP;
          end
        rv_core_pkg::WAIT_PC:
          if (pc_valid_i)
          begin
            pc_q    <= next_pc_i;
            state_q <= rv_core_pkg::LOOKUP;
          end
        default: state_q <= rv_core_pkg::LOOKUP;
      endcase
    end
  end

  // line data, tags and the bus address.
  always_ff @(posedge clk)
  begin
    if (state_q == rv_core_pkg::LOOKUP && !hit)
      paddr_o <= {pc_q[31:IDX_LSB], rv_core_pkg::l1i_off_t'(0), 2'b00};
    if (state_q == rv_core_pkg::FILL_LO && xfer_done)
    begin
      l1i_data[pc_idx][0] <= prdata_i;
      paddr_o             <= {pc_q[31:IDX_LSB], rv_core_pkg::l1i_off_t'(1), 2'b00};
    end
    if (state_q == rv_core_pkg::FILL_HI && xfer_done)
    begin
      l1i_data[pc_idx][1] <= prdata_i;
      l1i_tag[pc_idx]     <= pc_tag;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/rv_decode.sv ====
`default_nettype none

`include "rv_core_cfg.svh"

module rv_decode (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  inst_valid_i,
  input  rv_core_pkg::word_t    inst_i,
  input  rv_core_pkg::addr_t    pc_i,
  input  rv_core_pkg::word_t    rs1_val_i,
  input  rv_core_pkg::word_t    rs2_val_i,
  output rv_core_pkg::reg_idx_t rs1_o,
  output rv_core_pkg::reg_idx_t rs2_o,
  output logic                  dec_valid_o,
  output rv_core_pkg::word_t    op_a_o,
  output rv_core_pkg::word_t    op_b_o,
  output rv_core_pkg::word_t    imm_o,
  output rv_core_pkg::alu_op_e  alu_op_o,
  output logic                  is_branch_o,
  output logic                  branch_ne_o,
  output logic                  is_jal_o,
  output logic                  uses_imm_o,
  output logic                  writes_rd_o,
  output rv_core_pkg::reg_idx_t rd_o,
  output rv_core_pkg::addr_t    pc_o
);

  rv_core_pkg::opcode_t opcode;
  logic [2:0]           funct3;
  rv_core_pkg::word_t   imm;
  rv_core_pkg::alu_op_e alu_op;
  logic                 is_branch;
  logic                 branch_ne;
  logic                 is_jal;
  logic                 uses_imm;
  logic                 writes_rd;

  assign opcode = inst_i[6:0];
  assign funct3 = inst_i[14:12];
  assign rs1_o  = inst_i[19:15]; // register file read is combinational.
  assign rs2_o  = inst_i[24:20];

  always_comb
  begin
    imm       = '0;
    alu_op    = rv_core_pkg::ALU_ADD;
    is_branch = 1'b0;
    branch_ne = 1'b0;
    is_jal    = 1'b0;
    uses_imm  = 1'b0;
    writes_rd = 1'b0;
    case (opcode)
      `RV_OP_LUI:
      begin
        imm       = {inst_i[31:12], 12'b0};
        alu_op    = rv_core_pkg::ALU_PASS_B;
        uses_imm  = 1'b1;
        writes_rd = 1'b1;
      end
      `RV_OP_IMM:
      begin
        imm       = {{20{inst_i[31]}}, inst_i[31:20]};
        uses_imm  = 1'b1;
        writes_rd = (funct3 == 3'b000); // addi only.
      end
      `RV_OP_REG:
      begin
        alu_op    = inst_i[30] ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
        writes_rd = 1'b1;
      end
      `RV_OP_BRANCH:
      begin
        imm       = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                     inst_i[11:8], 1'b0};
        is_branch = 1'b1;
        branch_ne = funct3[0]; // beq 000, bne 001.
      end
      `RV_OP_JAL:
      begin
        imm       = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                     inst_i[30:21], 1'b0};
        is_jal    = 1'b1;
        writes_rd = 1'b1;
      end
      // fence.i only moves the pc, fetch already dropped the lines.
      `RV_OP_MISC_MEM: writes_rd = 1'b0;
      default: ;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      dec_valid_o <= 1'b0;
    else
      dec_valid_o <= inst_valid_i;
  end

  always_ff @(posedge clk)
  begin
    op_a_o      <= rs1_val_i;
    op_b_o      <= rs2_val_i;
    imm_o       <= imm;
    alu_op_o    <= alu_op;
    is_branch_o <= is_branch;
    branch_ne_o <= branch_ne;
    is_jal_o    <= is_jal;
    uses_imm_o  <= uses_imm;
    writes_rd_o <= writes_rd;
    rd_o        <= inst_i[11:7];
    pc_o        <= pc_i;
  end

endmodule

`default_nettype wire

// ==== hdl/rv_execute.sv ====
`default_nettype none

module rv_execute (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  dec_valid_i,
  input  rv_core_pkg::word_t    op_a_i,
  input  rv_core_pkg::word_t    op_b_i,
  input  rv_core_pkg::word_t    imm_i,
  input  rv_core_pkg::alu_op_e  alu_op_i,
  input  logic                  is_branch_i,
  input  logic                  branch_ne_i,
  input  logic                  is_jal_i,
  input  logic                  uses_imm_i,
  input  logic                  writes_rd_i,
  input  rv_core_pkg::reg_idx_t rd_i,
  input  rv_core_pkg::addr_t    pc_i,
  output logic                  ex_valid_o,
  output rv_core_pkg::word_t    result_o,
  output rv_core_pkg::reg_idx_t rd_o,
  output logic                  writes_rd_o,
  output rv_core_pkg::addr_t    next_pc_o,
  output rv_core_pkg::addr_t    pc_o
);

  rv_core_pkg::word_t alu_b;
  rv_core_pkg::word_t alu_out;
  rv_core_pkg::addr_t pc_plus4;
  rv_core_pkg::addr_t pc_target;
  logic               taken;

  assign alu_b = uses_imm_i ? imm_i : op_b_i;

  always_comb
  begin
    case (alu_op_i)
      rv_core_pkg::ALU_SUB:    alu_out = op_a_i - alu_b;
      rv_core_pkg::ALU_PASS_B: alu_out = alu_b;
      default:                 alu_out = op_a_i + alu_b;
    endcase
  end

  assign pc_plus4  = pc_i + 32'd4;
  assign pc_target = pc_i + imm_i;

  // beq takes on equal operands, bne on unequal.
  assign taken = is_branch_i && ((op_a_i == op_b_i) != branch_ne_i);

  always_ff @(posedge clk)
  begin
    if (rst)
      ex_valid_o <= 1'b0;
    else
      ex_valid_o <= dec_valid_i;
  end

  always_ff @(posedge clk)
  begin
    result_o    <= is_jal_i ? pc_plus4 : alu_out; // link address for jal.
    rd_o        <= rd_i;
    writes_rd_o <= writes_rd_i;
    next_pc_o   <= (taken || is_jal_i) ? pc_target : pc_plus4;
    pc_o        <= pc_i;
  end

endmodule

`default_nettype wire

// ==== hdl/rv_result.sv ====
`default_nettype none

module rv_result (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  ex_valid_i,
  input  rv_core_pkg::word_t    result_i,
  input  rv_core_pkg::reg_idx_t rd_i,
  input  logic                  writes_rd_i,
  input  rv_core_pkg::addr_t    next_pc_i,
  input  rv_core_pkg::addr_t    pc_i,
  input  rv_core_pkg::reg_idx_t rs1_i,
  input  rv_core_pkg::reg_idx_t rs2_i,
  output rv_core_pkg::word_t    rs1_val_o,
  output rv_core_pkg::word_t    rs2_val_o,
  output logic                  pc_valid_o,
  output rv_core_pkg::addr_t    next_pc_o,
  output logic                  retire_valid_o,
  output rv_core_pkg::addr_t    retire_pc_o,
  output rv_core_pkg::reg_idx_t retire_rd_o,
  output rv_core_pkg::word_t    retire_data_o
);

  rv_core_pkg::word_t regs [1:31]; // x0 has no storage.
  logic               wr_en;

  assign wr_en = ex_valid_i && writes_rd_i && (rd_i != '0);

  assign rs1_val_o = (rs1_i == '0) ? '0 : regs[rs1_i];
  assign rs2_val_o = (rs2_i == '0) ? '0 : regs[rs2_i];

  always_ff @(posedge clk)
  begin
    if (wr_en)
      regs[rd_i] <= result_i;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      retire_valid_o <= 1'b0;
    else
      retire_valid_o <= ex_valid_i;
  end

  // writes to x0 retire as no write at all.
  always_ff @(posedge clk)
  begin
    retire_pc_o   <= pc_i;
    retire_rd_o   <= wr_en ? rd_i : '0;
    retire_data_o <= wr_en ? result_i : '0;
    next_pc_o     <= next_pc_i;
  end

  assign pc_valid_o = retire_valid_o; // fetch resumes with the retire.

endmodule

`default_nettype wire

// ==== hdl/rv_core_top.sv ====
`default_nettype none

module rv_core_top (
  input  logic                  clk,
  input  logic                  rst,
  output logic                  psel_o,
  output logic                  penable_o,
  output rv_core_pkg::addr_t    paddr_o,
  input  rv_core_pkg::word_t    prdata_i,
  input  logic                  pready_i,
  output logic                  retire_valid_o,
  output rv_core_pkg::addr_t    retire_pc_o,
  output rv_core_pkg::reg_idx_t retire_rd_o,
  output rv_core_pkg::word_t    retire_data_o
);

  logic                  inst_valid, pc_valid, dec_valid, ex_valid;
  rv_core_pkg::word_t    inst, rs1_val, rs2_val, op_a, op_b, imm, ex_result;
  rv_core_pkg::addr_t    f_pc, d_pc, ex_pc, ex_next_pc, next_pc;
  rv_core_pkg::reg_idx_t rs1, rs2, d_rd, ex_rd;
  rv_core_pkg::alu_op_e  alu_op;
  logic                  is_branch, branch_ne, is_jal, uses_imm;
  logic                  d_writes_rd, ex_writes_rd;

  rv_fetch u_rv_fetch (
    .clk          (clk),
    .rst          (rst),
    .pc_valid_i   (pc_valid),
    .next_pc_i    (next_pc),
    .psel_o       (psel_o),
    .penable_o    (penable_o),
    .paddr_o      (paddr_o),
    .prdata_i     (prdata_i),
    .pready_i     (pready_i),
    .inst_valid_o (inst_valid),
    .inst_o       (inst),
    .pc_o         (f_pc)
  );

  rv_decode u_rv_decode (
    .clk          (clk),
    .rst          (rst),
    .inst_valid_i (inst_valid),
    .inst_i       (inst),
    .pc_i         (f_pc),
    .rs1_val_i    (rs1_val),
    .rs2_val_i    (rs2_val),
    .rs1_o        (rs1),
    .rs2_o        (rs2),
    .dec_valid_o  (dec_valid),
    .op_a_o       (op_a),
    .op_b_o       (op_b),
    .imm_o        (imm),
    .alu_op_o     (alu_op),
    .is_branch_o  (is_branch),
    .branch_ne_o  (branch_ne),
    .is_jal_o     (is_jal),
    .uses_imm_o   (uses_imm),
    .writes_rd_o  (d_writes_rd),
    .rd_o         (d_rd),
    .pc_o         (d_pc)
  );

  rv_execute u_rv_execute (
    .clk         (clk),
    .rst         (rst),
    .dec_valid_i (dec_valid),
    .op_a_i      (op_a),
    .op_b_i      (op_b),
    .imm_i       (imm),
    .alu_op_i    (alu_op),
    .is_branch_i (is_branch),
    .branch_ne_i (branch_ne),
    .is_jal_i    (is_jal),
    .uses_imm_i  (uses_imm),
    .writes_rd_i (d_writes_rd),
    .rd_i        (d_rd),
    .pc_i        (d_pc),
    .ex_valid_o  (ex_valid),
    .result_o    (ex_result),
    .rd_o        (ex_rd),
    .writes_rd_o (ex_writes_rd),
    .next_pc_o   (ex_next_pc),
    .pc_o        (ex_pc)
  );

  rv_result u_rv_result (
    .clk            (clk),
    .rst            (rst),
    .ex_valid_i     (ex_valid),
    .result_i       (ex_result),
    .rd_i           (ex_rd),
    .writes_rd_i    (ex_writes_rd),
    .next_pc_i      (ex_next_pc),
    .pc_i           (ex_pc),
    .rs1_i          (rs1),
    .rs2_i          (rs2),
    .rs1_val_o      (rs1_val),
    .rs2_val_o      (rs2_val),
    .pc_valid_o     (pc_valid),
    .next_pc_o      (next_pc),
    .retire_valid_o (retire_valid_o),
    .retire_pc_o    (retire_pc_o),
    .retire_rd_o    (retire_rd_o),
    .retire_data_o  (retire_data_o)
  );

endmodule

`default_nettype wire

// ==== testbench/rv_core_sva.sv ====
`default_nettype none

module rv_core_sva (
  input logic               clk,
  input logic               rst,
  input logic               psel_o,
  input logic               penable_o,
  input rv_core_pkg::addr_t paddr_o,
  input logic               pready_i,
  input logic               retire_valid_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // setup phase moves to the access phase with the address held.
  apb_setup_to_access: assert property (@(posedge clk) disable iff (rst)
    psel_o && !penable_o |=> psel_o && penable_o && $stable(paddr_o))
    else $error("apb access phase did not follow the setup phase");

  apb_enable_with_sel: assert property (@(posedge clk) disable iff (rst)
    penable_o |-> psel_o)
    else $error("apb penable high without psel");

  // wait states keep the transfer unchanged.
  apb_hold_until_ready: assert property (@(posedge clk) disable iff (rst)
    psel_o && penable_o && !pready_i |=> psel_o && penable_o && $stable(paddr_o))
    else $error("apb transfer changed before pready");

  retire_single_pulse: assert property (@(posedge clk) disable iff (rst)
    retire_valid_o |=> !retire_valid_o)
    else $error("retire valid high in two consecutive cycles");

endmodule

`default_nettype wire

// ==== testbench/rv_core_tb.sv ====
`default_nettype none

`include "rv_core_cfg.svh"

module rv_core_tb;

  timeunit 1ns;
  timeprecision 1ps;

  logic                  clk;
  logic                  rst;
  logic                  psel;
  logic                  penable;
  rv_core_pkg::addr_t    paddr;
  rv_core_pkg::word_t    prdata;
  logic                  pready;
  logic                  retire_valid;
  rv_core_pkg::addr_t    retire_pc;
  rv_core_pkg::reg_idx_t retire_rd;
  rv_core_pkg::word_t    retire_data;

  logic [31:0] mem [64]; // program memory behind the apb port.
  int          xfers;
  int unsigned wait_left;
  logic [31:0] exp_addr;
  int          entry; // table entry whose retire is awaited.

  // one entry per expected retire, in order.
  string       tname[$];
  logic [31:0] tpc[$];
  logic [4:0]  trd[$];
  logic [31:0] tdata[$];
  int          txfers[$];

  rv_core_top u_rv_core_top (
    .clk            (clk),
    .rst            (rst),
    .psel_o         (psel),
    .penable_o      (penable),
    .paddr_o        (paddr),
    .prdata_i       (prdata),
    .pready_i       (pready),
    .retire_valid_o (retire_valid),
    .retire_pc_o    (retire_pc),
    .retire_rd_o    (retire_rd),
    .retire_data_o  (retire_data)
  );

  bind rv_core_top rv_core_sva u_rv_core_sva (
    .clk            (clk),
    .rst            (rst),
    .psel_o         (psel_o),
    .penable_o      (penable_o),
    .paddr_o        (paddr_o),
    .pready_i       (pready_i),
    .retire_valid_o (retire_valid_o)
  );

  function automatic logic [31:0] lui(input int rd, input int imm);
    return {imm[19:0], rd[4:0], 7'b0110111};
  endfunction

  function automatic logic [31:0] addi(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
  endfunction

  function automatic logic [31:0] reg_op(input int funct7, input int rd, input int rs1,
                                         input int rs2);
    return {funct7[6:0], rs2[4:0], rs1[4:0], 3'b000, rd[4:0], 7'b0110011};
  endfunction

  // funct3 0 is beq, 1 is bne.
  function automatic logic [31:0] branch(input int funct3, input int rs1, input int rs2,
                                         input int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], funct3[2:0], off[4:1], off[11],
            7'b1100011};
  endfunction

  function automatic logic [31:0] jal(input int rd, input int off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
  endfunction

  function automatic logic [31:0] fence_i();
    return {12'b0, 5'b0, 3'b001, 5'b0, 7'b0001111};
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_mismatch(input string test, input string field,
                                 input logic [31:0] exp, input logic [31:0] act);
    abort_run($sformatf("MISMATCH %s %s expected %h actual %h", test, field, exp, act));
  endtask

  // place the instruction and queue the retire it must produce.
  task automatic step(input string name, input int pc, input logic [31:0] inst,
                      input int rd, input logic [31:0] data, input int xfers_at);
    mem[6'(pc >> 2)] = inst;
    tname.push_back(name);
    tpc.push_back(pc);
    trd.push_back(rd[4:0]);
    tdata.push_back(data);
    txfers.push_back(xfers_at);
  endtask

  task automatic load_table();
    step("lui x1",          `RV_RESET_PC, lui(1, 'h12345), 1, 32'h1234_5000, 2);
    step("addi x2",         'h04, addi(2, 1, 'h678),       2, 32'h1234_5678, 2);
    step("add x3",          'h08, reg_op(0, 3, 1, 2),      3, 32'h2468_a678, 4);
    step("sub x4",          'h0c, reg_op('h20, 4, 2, 1),   4, 32'h0000_0678, 4);
    step("addi x0",         'h10, addi(0, 2, 5),           0, 32'h0, 6);
    step("add x5 from x0",  'h14, reg_op(0, 5, 0, 4),      5, 32'h0000_0678, 6);
    step("addi x6 neg",     'h18, addi(6, 0, -3),          6, 32'hffff_fffd, 8);
    step("beq taken",       'h1c, branch(0, 5, 4, 8),      0, 32'h0, 8);
    step("bne not taken",   'h24, branch(1, 5, 4, 100),    0, 32'h0, 10);
    step("beq not taken",   'h28, branch(0, 6, 0, 100),    0, 32'h0, 12);
    step("bne taken",       'h2c, branch(1, 6, 0, 8),      0, 32'h0, 12);
    step("jal x8",          'h34, jal(8, 12),              8, 32'h0000_0038, 14);
    step("loop init",       'h40, addi(9, 0, 3),           9, 32'h3, 16);
    step("loop pass 1",     'h44, addi(9, 9, -1),          9, 32'h2, 16);
    step("loop branch 1",   'h48, branch(1, 9, 0, -4),     0, 32'h0, 18);
    step("loop pass 2",     'h44, addi(9, 9, -1),          9, 32'h1, 18);
    step("loop branch 2",   'h48, branch(1, 9, 0, -4),     0, 32'h0, 18);
    step("loop pass 3",     'h44, addi(9, 9, -1),          9, 32'h0, 18);
    step("loop exit",       'h48, branch(1, 9, 0, -4),     0, 32'h0, 18);
    step("jal far",         'h4c, jal(0, 'h34),            0, 32'h0, 18);
    step("jal x10",         'h80, jal(10, 'h20),          10, 32'h0000_0084, 20);
    step("conflict line",   'ha0, addi(11, 0, 'h55),      11, 32'h0000_0055, 22);
    step("jal back",        'ha4, jal(0, -'h20),           0, 32'h0, 22);
    step("evicted refill",  'h84, addi(13, 11, -'h55),    13, 32'h0, 24);
    step("fence.i first",   'h88, fence_i(),               0, 32'h0, 26);
    step("count 1",         'h8c, addi(13, 13, 1),        13, 32'h1, 28);
    step("limit 1",         'h90, addi(14, 0, 2),         14, 32'h2, 30);
    step("fence loop back", 'h94, branch(1, 13, 14, -12),  0, 32'h0, 30);
    step("fence.i second",  'h88, fence_i(),               0, 32'h0, 30);
    step("count 2",         'h8c, addi(13, 13, 1),        13, 32'h2, 32);
    step("limit 2",         'h90, addi(14, 0, 2),         14, 32'h2, 34);
    step("fence loop exit", 'h94, branch(1, 13, 14, -12),  0, 32'h0, 34);
    step("jal self",        'h98, jal(0, 0),               0, 32'h0, 36);
  endtask

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // apb memory with 0 to 2 random wait states per transfer.
  initial
  begin
    void'($urandom(32'hd7e3c5df));
    pready    = 1'b0;
    prdata    = '0;
    wait_left = 0;
    xfers     = 0;
    forever
    begin
      @(negedge clk);
      if (psel && !penable)
      begin
        pready    = 1'b0;
        wait_left = $urandom % 3;
      end
      else if (psel && penable)
      begin
        if (wait_left == 0)
        begin
          // a fill reads the line of the next pc, low word first.
          exp_addr = {tpc[entry][31:3], xfers[0], 2'b00};
          assert (paddr == exp_addr)
            else report_mismatch(tname[entry], "apb address", exp_addr, paddr);
          prdata    = mem[paddr[7:2]];
          pready    = 1'b1; // completes at the next rising edge.
          xfers     = xfers + 1;
        end
        else
          wait_left = wait_left - 1;
      end
      else
        pready = 1'b0;
    end
  end

  initial
  begin
    @(negedge rst);
    repeat (tname.size() * 200) @(posedge clk);
    abort_run("timeout, no retire arrived in the allowed time");
  end

  initial
  begin
    rst = 1'b1;
    for (int i = 0; i < 64; i++)
      mem[6'(i)] = 32'h0bad_0000 + 32'(i);
    load_table();
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (entry = 0; entry < tname.size(); entry++)
    begin
      @(negedge clk);
      while (!retire_valid)
        @(negedge clk);
      assert (retire_pc == tpc[entry])
        else report_mismatch(tname[entry], "pc", tpc[entry], retire_pc);
      assert (retire_rd == trd[entry])
        else report_mismatch(tname[entry], "rd", 32'(trd[entry]), 32'(retire_rd));
      assert (retire_data == tdata[entry])
        else report_mismatch(tname[entry], "data", tdata[entry], retire_data);
      assert (xfers == txfers[entry])
        else report_mismatch(tname[entry], "apb transfers", 32'(txfers[entry]), 32'(xfers));
    end
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+hdl
hdl/rv_core_pkg.sv
hdl/rv_fetch.sv
hdl/rv_decode.sv
hdl/rv_execute.sv
hdl/rv_result.sv
hdl/rv_core_top.sv
testbench/rv_core_sva.sv
testbench/rv_core_tb.sv

// ==== Makefile ====
TOP = rv_core_tb

sim:
	verilator --binary --assert --timescale 1ns/1ps --top-module $(TOP) -f verilog.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
